// File: Bender.yml
package:
  name: zynq_shell

sources:
  - zynq_shell_pkg.sv
  - zynq_shell_csr.sv
  - dram_req_xlate.sv
  - dram_profiler.sv
  - zynq_shell_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_checker.sv
      - tb_zynq_shell.sv

// File: build.f
zynq_shell_pkg.sv
zynq_shell_csr.sv
dram_req_xlate.sv
dram_profiler.sv
zynq_shell_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_zynq_shell.sv

// File: dram_profiler.sv
`timescale 1ns/1ps

module dram_profiler
   #(parameter int REGION_TOP = zynq_shell_pkg::REGION_MSB)
   (input  logic                          aclk
    , input  logic                        rst_n_i

    // held high while the accelerator is in reset
    , input  logic                        clear_i

    , input  logic                        accept_i
    , input  zynq_shell_pkg::paddr_t      accept_addr_i

    , output zynq_shell_pkg::region_map_t region_map_o
    , output zynq_shell_pkg::req_count_t  req_count_o
    );

   import zynq_shell_pkg::*;

   localparam int REGION_W = $clog2(NUM_REGIONS);

   region_map_t         region_map_r;
   req_count_t          req_count_r;
   logic [REGION_W-1:0] region_idx;

   // one region per 2^(REGION_TOP-REGION_W+1) bytes
   assign region_idx = accept_addr_i[REGION_TOP -: REGION_W];

   always_ff @(posedge aclk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         region_map_r <= '0;
         req_count_r  <= '0;
      end else if (clear_i) begin
         region_map_r <= '0;
         req_count_r  <= '0;
      end else if (accept_i) begin
         // sticky until the next clear
         region_map_r[region_idx] <= 1'b1;
         req_count_r              <= req_count_r + 1'b1;
      end
   end

   assign region_map_o = region_map_r;
   assign req_count_o  = req_count_r;

endmodule

// File: dram_req_xlate.sv
`timescale 1ns/1ps

module dram_req_xlate
   #(parameter zynq_shell_pkg::paddr_t ACC_BASE = zynq_shell_pkg::ACC_DRAM_BASE)
   (input  logic                     aclk
    , input  logic                   rst_n_i

    , input  logic                   req_enable_i
    , input  zynq_shell_pkg::paddr_t dram_base_i

    // request from the accelerator
    , input  logic                   acc_req_valid_i
    , input  zynq_shell_pkg::paddr_t acc_req_addr_i
    , input  logic                   acc_req_write_i
    , output logic                   acc_req_ready_o

    // translated request to host DRAM
    , output logic                   dram_req_valid_o
    , output zynq_shell_pkg::paddr_t dram_req_addr_o
    , output logic                   dram_req_write_o
    , input  logic                   dram_req_ready_i

    // accept report for the profiler
    , output logic                   accept_o
    , output zynq_shell_pkg::paddr_t accept_addr_o
    );

   import zynq_shell_pkg::*;

   logic   valid_r;
   paddr_t addr_r;
   logic   write_r;

   logic   accept;
   paddr_t xlate_addr;

   // accelerator DRAM base moves to zero, then the host buffer base is added
   assign xlate_addr = (acc_req_addr_i ^ ACC_BASE) + dram_base_i;

   // take a new request when the stage is empty or draining this cycle
   assign acc_req_ready_o = req_enable_i & (~valid_r | dram_req_ready_i);
   assign accept          = acc_req_valid_i & acc_req_ready_o;

   always_ff @(posedge aclk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_r <= 1'b0;
         addr_r  <= '0;
         write_r <= 1'b0;
      end else if (accept) begin
         valid_r <= 1'b1;
         addr_r  <= xlate_addr;
         write_r <= acc_req_write_i;
      end else if (dram_req_ready_i) begin
         // drains even if the enable has dropped
         valid_r <= 1'b0;
      end
   end

   assign dram_req_valid_o = valid_r;
   assign dram_req_addr_o  = addr_r;
   assign dram_req_write_o = write_r;

   // profiler sees the untranslated address
   assign accept_o      = accept;
   assign accept_addr_o = acc_req_addr_i;

endmodule

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker
   (input  logic                   aclk
    , input  logic                 rst_n_i
    , input  logic                 psel_i
    , input  logic                 penable_i
    , input  logic                 pwrite_i
    , input  zynq_shell_pkg::paddr_t paddr_i
    , input  zynq_shell_pkg::word_t  pwdata_i
    , input  zynq_shell_pkg::word_t  prdata_i
    , input  logic                 pready_i
    , input  logic                 pslverr_i
    , input  logic                 acc_req_valid_i
    , input  zynq_shell_pkg::paddr_t acc_req_addr_i
    , input  logic                 acc_req_write_i
    , input  logic                 acc_req_ready_i
    , input  logic                 dram_req_valid_i
    , input  zynq_shell_pkg::paddr_t dram_req_addr_i
    , input  logic                 dram_req_write_i
    , input  logic                 dram_req_ready_i
    , input  logic                 acc_reset_n_i
    // expectations from the stim record in flight
    , input  zynq_shell_pkg::word_t  exp_data_i
    , input  logic                 exp_err_i
    , input  logic                 exp_model_i
    , input  logic                 test_done_i
    , input  byte                  test_kind_i
    , input  logic                 report_i
    , output int                   err_count_o
    , output int                   pending_o
    );

   import zynq_shell_pkg::*;

   paddr_t      exp_addr_q[$];
   logic        exp_write_q[$];
   logic [127:0] model_map;
   logic [63:0] model_cnt;
   logic        model_run;
   logic        model_alloc;
   paddr_t      model_base;
   logic        held;
   paddr_t      held_addr;
   logic        held_write;
   int          errs_at_start;
   int          tests_run;
   int          tests_failed;

   // expected word of a read-only offset
   function automatic word_t model_word(input logic [5:0] a);
      case (a)
         6'h0c:   return model_map[31:0];
         6'h10:   return model_map[63:32];
         6'h14:   return model_map[95:64];
         6'h18:   return model_map[127:96];
         6'h1c:   return model_cnt[31:0];
         6'h20:   return model_cnt[63:32];
         default: return 32'h0;
      endcase
   endfunction

   always @(posedge aclk or negedge rst_n_i) begin
      paddr_t exp_a;
      logic   exp_w;
      word_t  exp_rd;
      if (!rst_n_i) begin
         exp_addr_q.delete();
         exp_write_q.delete();
         model_map   = '0;
         model_cnt   = '0;
         model_run   = 1'b0;
         model_alloc = 1'b0;
         model_base  = '0;
         held        = 1'b0;
         err_count_o = 0;
         pending_o   = 0;
         errs_at_start = 0;
         tests_run     = 0;
         tests_failed  = 0;
      end else begin
         // APB access cycle, compared against state before this edge
         if (psel_i && penable_i) begin
            if (!pready_i) begin
               $display("APB access at %0t completed without pready", $time);
               err_count_o++;
            end
            if (pslverr_i !== exp_err_i) begin
               $display("mismatch at %0t: pslverr %b, expected %b, addr %h",
                        $time, pslverr_i, exp_err_i, paddr_i);
               err_count_o++;
            end
            if (!pwrite_i) begin
               exp_rd = exp_model_i ? model_word(paddr_i[5:0]) : exp_data_i;
               if (prdata_i !== exp_rd) begin
                  $display("mismatch at %0t: read %h from %h, expected %h",
                           $time, prdata_i, paddr_i, exp_rd);
                  err_count_o++;
               end
            end
         end
         if (acc_reset_n_i !== model_run) begin
            $display("mismatch at %0t: acc_reset_n_o %b, run bit %b",
                     $time, acc_reset_n_i, model_run);
            err_count_o++;
         end
         // accelerator side and profiler model
         if (!model_run) begin
            model_map = '0;
            model_cnt = '0;
         end
         if (acc_req_valid_i && acc_req_ready_i) begin
            if (!(model_run && model_alloc)) begin
               $display("request accepted at %0t while the shell is disabled", $time);
               err_count_o++;
            end
            // bit 31 inverted, then the host base added
            exp_addr_q.push_back({~acc_req_addr_i[31], acc_req_addr_i[30:0]} + model_base);
            exp_write_q.push_back(acc_req_write_i);
            model_map[acc_req_addr_i[29:23]] = 1'b1;
            model_cnt = model_cnt + 1;
         end
         // DRAM side
         if (held && (!dram_req_valid_i || dram_req_addr_i !== held_addr
                      || dram_req_write_i !== held_write)) begin
            $display("mismatch at %0t: held request changed to %b %h %b",
                     $time, dram_req_valid_i, dram_req_addr_i, dram_req_write_i);
            err_count_o++;
         end
         if (dram_req_valid_i && dram_req_ready_i) begin
            if (exp_addr_q.size() == 0) begin
               $display("request %h left at %0t with none accepted", dram_req_addr_i, $time);
               err_count_o++;
            end else begin
               exp_a = exp_addr_q.pop_front();
               exp_w = exp_write_q.pop_front();
               if (dram_req_addr_i !== exp_a || dram_req_write_i !== exp_w) begin
                  $display("mismatch at %0t: dram request %h/%b, expected %h/%b",
                           $time, dram_req_addr_i, dram_req_write_i, exp_a, exp_w);
                  err_count_o++;
               end
            end
         end
         held       = dram_req_valid_i && !dram_req_ready_i;
         held_addr  = dram_req_addr_i;
         held_write = dram_req_write_i;
         pending_o  = exp_addr_q.size();
         // register writes take effect at this edge
         if (psel_i && penable_i && pwrite_i) begin
            case (paddr_i[5:0])
               6'h00: model_run   = pwdata_i[0];
               6'h04: model_alloc = pwdata_i[0];
               6'h08: model_base  = pwdata_i;
               default: ;
            endcase
         end
         if (test_done_i) begin
            tests_run++;
            if (err_count_o != errs_at_start) begin
               tests_failed++;
               $display("test %0d (%c): failed", tests_run, test_kind_i);
            end else begin
               $display("test %0d (%c): ok", tests_run, test_kind_i);
            end
            errs_at_start = err_count_o;
         end
         if (report_i)
            $display("%0d tests run, %0d failed, %0d errors",
                     tests_run, tests_failed, err_count_o);
      end
   end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen
   #(parameter int PERIOD_NS  = 20
     , parameter int RST_CYCLES = 16)
   (output logic clk_o
    , output logic rst_n_o
    );

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // reset released on a rising edge after the hold time
   initial begin
      rst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

// File: tb_stim.txt
# kind addr data err : W write, R read with expected data, P read checked against the model
# kind count bp blocked : B request burst, bp random back-pressure, blocked expects no accept
W 08 12340000 0
R 08 12340000 0
W 04 00000001 0
R 04 00000001 0
W 00 00000001 0
R 00 00000001 0
W 00 a5a5a5a5 0
R 00 a5a5a5a5 0
R 24 00000000 1
R 3c 00000000 1
R 30 00000000 1
W 0c ffffffff 1
W 1c 00000001 1
W 20 00000001 1
W 28 00000001 1
R 0c 00000000 0
R 1c 00000000 0
R 08 12340000 0
R 04 00000001 0
B 10 0 0
P 0c 0 0
P 10 0 0
P 14 0 0
P 18 0 0
P 1c 0 0
P 20 0 0
B 20 1 0
P 1c 0 0
P 20 0 0
P 0c 0 0
W 08 00100000 0
B 18 1 0
P 0c 0 0
P 10 0 0
P 14 0 0
P 18 0 0
P 1c 0 0
W 04 00000000 0
B 4 0 1
P 1c 0 0
W 04 00000001 0
W 00 00000000 0
B 4 0 1
R 0c 00000000 0
R 18 00000000 0
R 1c 00000000 0
R 20 00000000 0
W 00 00000001 0
B 8 1 0
P 1c 0 0
P 14 0 0

// File: tb_zynq_shell.sv
`timescale 1ns/1ps

module tb_zynq_shell;

   import zynq_shell_pkg::*;

   localparam int CLK_NS    = 20;
   localparam int WD_CYCLES = 200;

   logic aclk, rst_n;
   logic psel, penable, pwrite;
   paddr_t paddr;
   word_t pwdata, prdata;
   logic pready, pslverr;
   logic acc_req_valid, acc_req_write, acc_req_ready;
   paddr_t acc_req_addr, dram_req_addr;
   logic dram_req_valid, dram_req_write, dram_req_ready;
   logic acc_reset_n;
   word_t exp_data;
   logic exp_err, exp_model, test_done, report, bp_mode;
   byte test_kind;
   int err_count, pending, fd;
   byte rec_kind[$];
   word_t rec_a[$], rec_b[$], rec_c[$];
   logic [15:0] addr_lfsr, bp_lfsr;

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic take_bits(input int n, output word_t v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], addr_lfsr[15]};
         addr_lfsr = lfsr_step(addr_lfsr);
      end
   endtask

   tb_clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(16)) clk_gen (.clk_o(aclk), .rst_n_o(rst_n));

   zynq_shell_top DUT
     (.aclk(aclk), .rst_n_i(rst_n), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite)
      ,.paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready)
      ,.pslverr_o(pslverr), .acc_req_valid_i(acc_req_valid), .acc_req_addr_i(acc_req_addr)
      ,.acc_req_write_i(acc_req_write), .acc_req_ready_o(acc_req_ready)
      ,.dram_req_valid_o(dram_req_valid), .dram_req_addr_o(dram_req_addr)
      ,.dram_req_write_o(dram_req_write), .dram_req_ready_i(dram_req_ready)
      ,.acc_reset_n_o(acc_reset_n));

   tb_checker chk
     (.aclk(aclk), .rst_n_i(rst_n), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite)
      ,.paddr_i(paddr), .pwdata_i(pwdata), .prdata_i(prdata), .pready_i(pready)
      ,.pslverr_i(pslverr), .acc_req_valid_i(acc_req_valid), .acc_req_addr_i(acc_req_addr)
      ,.acc_req_write_i(acc_req_write), .acc_req_ready_i(acc_req_ready)
      ,.dram_req_valid_i(dram_req_valid), .dram_req_addr_i(dram_req_addr)
      ,.dram_req_write_i(dram_req_write), .dram_req_ready_i(dram_req_ready)
      ,.acc_reset_n_i(acc_reset_n), .exp_data_i(exp_data), .exp_err_i(exp_err)
      ,.exp_model_i(exp_model), .test_done_i(test_done), .test_kind_i(test_kind)
      ,.report_i(report), .err_count_o(err_count), .pending_o(pending));

   // DRAM side ready, random when back-pressure is on
   always @(posedge aclk) begin
      if (bp_mode) begin
         dram_req_ready <= bp_lfsr[15];
         bp_lfsr = lfsr_step(bp_lfsr);
      end else begin
         dram_req_ready <= 1'b1;
      end
   end

   task automatic apb_xfer(input logic wr, input paddr_t a, input word_t d,
                           input logic err, input logic model);
      psel      <= 1'b1;
      penable   <= 1'b0;
      pwrite    <= wr;
      paddr     <= a;
      pwdata    <= d;
      exp_data  <= d;
      exp_err   <= err;
      exp_model <= model;
      @(posedge aclk);
      penable <= 1'b1;
      do @(negedge aclk); while (!pready);
      @(posedge aclk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic run_burst(input int count, input logic bp, input logic blocked);
      word_t v;
      bp_mode <= bp;
      for (int i = 0; i < count; i++) begin
         take_bits(32, v);
         acc_req_addr <= v;
         take_bits(1, v);
         acc_req_write <= v[0];
         acc_req_valid <= 1'b1;
         if (blocked) begin
            repeat (4) @(posedge aclk);
         end else begin
            do @(negedge aclk); while (!acc_req_ready);
            @(posedge aclk);
         end
      end
      acc_req_valid <= 1'b0;
      bp_mode       <= 1'b0;
   endtask

   initial begin
      string line;
      byte   k;
      word_t a, b, c;
      {psel, penable, pwrite, paddr, pwdata} = '0;
      {acc_req_valid, acc_req_addr, acc_req_write, dram_req_ready} = '0;
      {exp_data, exp_err, exp_model, test_done, report, bp_mode} = '0;
      test_kind = "-";
      addr_lfsr = 16'd58060;
      bp_lfsr   = 16'd58060;
      fd = $fopen("tb_stim.txt", "r");
      if (fd == 0) begin
         $display("cannot open tb_stim.txt");
         $display("Simulation finished: FAIL");
         $finish;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#"
                && $sscanf(line, "%c %h %h %h", k, a, b, c) == 4) begin
               rec_kind.push_back(k);
               rec_a.push_back(a);
               rec_b.push_back(b);
               rec_c.push_back(c);
            end
         end
         $fclose(fd);
         fork
            begin
               #(rec_kind.size() * WD_CYCLES * CLK_NS);
               $display("watchdog expired before all records completed");
               $display("Simulation finished: FAIL");
               $finish;
            end
         join_none
         @(posedge rst_n);
         @(posedge aclk);
         for (int i = 0; i < rec_kind.size(); i++) begin
            case (rec_kind[i])
               "W": apb_xfer(1'b1, rec_a[i], rec_b[i], rec_c[i][0], 1'b0);
               "R": apb_xfer(1'b0, rec_a[i], rec_b[i], rec_c[i][0], 1'b0);
               "P": apb_xfer(1'b0, rec_a[i], '0, 1'b0, 1'b1);
               "B": run_burst(rec_a[i], rec_b[i][0], rec_c[i][0]);
               default: $display("unknown record kind %c skipped", rec_kind[i]);
            endcase
            test_kind <= rec_kind[i];
            test_done <= 1'b1;
            @(posedge aclk);
            test_done <= 1'b0;
         end
         // let the last requests leave the stage
         do @(negedge aclk); while (pending != 0);
         @(posedge aclk);
         report <= 1'b1;
         @(posedge aclk);
         report <= 1'b0;
         @(negedge aclk);
         if (err_count == 0)
            $display("Simulation finished: PASS");
         else
            $display("Simulation finished: FAIL");
         $finish;
      end
   end

endmodule

// File: zynq_shell_csr.sv
`timescale 1ns/1ps

module zynq_shell_csr
   (input  logic                          aclk
    , input  logic                        rst_n_i

    // APB slave port from the host
    , input  logic                        psel_i
    , input  logic                        penable_i
    , input  logic                        pwrite_i
    , input  zynq_shell_pkg::paddr_t      paddr_i
    , input  zynq_shell_pkg::word_t       pwdata_i
    , output zynq_shell_pkg::word_t       prdata_o
    , output logic                        pready_o
    , output logic                        pslverr_o

    // status from the profiler
    , input  zynq_shell_pkg::region_map_t region_map_i
    , input  zynq_shell_pkg::req_count_t  req_count_i

    // control outputs
    , output logic                        acc_reset_n_o
    , output logic                        req_enable_o
    , output zynq_shell_pkg::paddr_t      dram_base_o
    );

   import zynq_shell_pkg::*;

   word_t     ctrl_r;
   word_t     alloc_r;
   paddr_t    base_r;

   csr_addr_t csr_addr;
   logic      apb_access;
   logic      wr_en;
   logic      addr_hit;
   logic      addr_ro;
   word_t     rd_data;

   assign csr_addr   = paddr_i[CSR_ADDR_W-1:0];
   assign apb_access = psel_i & penable_i;
   assign wr_en      = apb_access & pwrite_i;

   // address decode and readback mux
   always_comb begin
      rd_data  = '0;
      addr_hit = 1'b1;
      addr_ro  = 1'b0;
      case (csr_addr)
         CSR_CTRL:  rd_data = ctrl_r;
         CSR_ALLOC: rd_data = alloc_r;
         CSR_BASE:  rd_data = base_r;
         CSR_PROF0: begin
            rd_data = region_map_i[0*DATA_W +: DATA_W];
            addr_ro = 1'b1;
         end
         CSR_PROF1: begin
            rd_data = region_map_i[1*DATA_W +: DATA_W];
            addr_ro = 1'b1;
         end
         CSR_PROF2: begin
            rd_data = region_map_i[2*DATA_W +: DATA_W];
            addr_ro = 1'b1;
         end
         CSR_PROF3: begin
            rd_data = region_map_i[3*DATA_W +: DATA_W];
            addr_ro = 1'b1;
         end
         CSR_CNT_LO: begin
            rd_data = req_count_i[DATA_W-1:0];
            addr_ro = 1'b1;
         end
         CSR_CNT_HI: begin
            rd_data = req_count_i[2*DATA_W-1:DATA_W];
            addr_ro = 1'b1;
         end
         default: addr_hit = 1'b0;
      endcase
   end

   // register writes, only the three rw offsets match here
   always_ff @(posedge aclk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_r  <= '0;
         alloc_r <= '0;
         base_r  <= '0;
      end else if (wr_en) begin
         case (csr_addr)
            CSR_CTRL:  ctrl_r  <= pwdata_i;
            CSR_ALLOC: alloc_r <= pwdata_i;
            CSR_BASE:  base_r  <= pwdata_i;
            default: ;
         endcase
      end
   end

   // zero wait states
   assign pready_o  = apb_access;
   assign pslverr_o = apb_access & (~addr_hit | (pwrite_i & addr_ro));
   assign prdata_o  = rd_data;

   // bit 0 of ctrl is the run bit, bit 0 of alloc the allocated flag
   assign acc_reset_n_o = ctrl_r[0];
   assign req_enable_o  = ctrl_r[0] & alloc_r[0];
   assign dram_base_o   = base_r;

endmodule

// File: zynq_shell_pkg.sv
package zynq_shell_pkg;

   // bus and register widths
   localparam int ADDR_W      = 32;
   localparam int DATA_W      = 32;
   localparam int NUM_REGIONS = 128;

   typedef logic [ADDR_W-1:0]      paddr_t;
   typedef logic [DATA_W-1:0]      word_t;
   typedef logic [NUM_REGIONS-1:0] region_map_t;
   typedef logic [63:0]            req_count_t;

   // profiler regions are 8 MB each, indexed by addr[29:23]
   localparam int REGION_MSB = 29;

   // start of accelerator DRAM space
   // this bit is flipped before the host buffer base is added
   localparam paddr_t ACC_DRAM_BASE = 32'h8000_0000;

   // only the low address bits of the APB port are decoded
   localparam int CSR_ADDR_W = 6;

   typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

   // host-writable registers
   localparam csr_addr_t CSR_CTRL  = 6'h00;
   localparam csr_addr_t CSR_ALLOC = 6'h04;
   localparam csr_addr_t CSR_BASE  = 6'h08;

   // read-only profiler bitmap, lowest region first
   localparam csr_addr_t CSR_PROF0 = 6'h0C;
   localparam csr_addr_t CSR_PROF1 = 6'h10;
   localparam csr_addr_t CSR_PROF2 = 6'h14;
   localparam csr_addr_t CSR_PROF3 = 6'h18;

   // read-only request counter
   localparam csr_addr_t CSR_CNT_LO = 6'h1C;
   localparam csr_addr_t CSR_CNT_HI = 6'h20;

endpackage

// File: zynq_shell_top.sv
`timescale 1ns/1ps

module zynq_shell_top
   (input  logic                     aclk
    , input  logic                   rst_n_i

    // APB port from the host
    , input  logic                   psel_i
    , input  logic                   penable_i
    , input  logic                   pwrite_i
    , input  zynq_shell_pkg::paddr_t paddr_i
    , input  zynq_shell_pkg::word_t  pwdata_i
    , output zynq_shell_pkg::word_t  prdata_o
    , output logic                   pready_o
    , output logic                   pslverr_o

    // accelerator DRAM requests
    , input  logic                   acc_req_valid_i
    , input  zynq_shell_pkg::paddr_t acc_req_addr_i
    , input  logic                   acc_req_write_i
    , output logic                   acc_req_ready_o

    // host DRAM requests
    , output logic                   dram_req_valid_o
    , output zynq_shell_pkg::paddr_t dram_req_addr_o
    , output logic                   dram_req_write_o
    , input  logic                   dram_req_ready_i

    // accelerator reset, low while run is clear
    , output logic                   acc_reset_n_o
    );

   import zynq_shell_pkg::*;

   logic        req_enable;
   paddr_t      dram_base;
   logic        accept;
   paddr_t      accept_addr;
   region_map_t region_map;
   req_count_t  req_count;
   logic        prof_clear;

   // profiler state lives only while the accelerator runs
   assign prof_clear = ~acc_reset_n_o;

   zynq_shell_csr csr
     (.aclk           (aclk)
      ,.rst_n_i       (rst_n_i)
      ,.psel_i        (psel_i)
      ,.penable_i     (penable_i)
      ,.pwrite_i      (pwrite_i)
      ,.paddr_i       (paddr_i)
      ,.pwdata_i      (pwdata_i)
      ,.prdata_o      (prdata_o)
      ,.pready_o      (pready_o)
      ,.pslverr_o     (pslverr_o)
      ,.region_map_i  (region_map)
      ,.req_count_i   (req_count)
      ,.acc_reset_n_o (acc_reset_n_o)
      ,.req_enable_o  (req_enable)
      ,.dram_base_o   (dram_base)
      );

   dram_req_xlate #(.ACC_BASE(ACC_DRAM_BASE)) xlate
     (.aclk              (aclk)
      ,.rst_n_i          (rst_n_i)
      ,.req_enable_i     (req_enable)
      ,.dram_base_i      (dram_base)
      ,.acc_req_valid_i  (acc_req_valid_i)
      ,.acc_req_addr_i   (acc_req_addr_i)
      ,.acc_req_write_i  (acc_req_write_i)
      ,.acc_req_ready_o  (acc_req_ready_o)
      ,.dram_req_valid_o (dram_req_valid_o)
      ,.dram_req_addr_o  (dram_req_addr_o)
      ,.dram_req_write_o (dram_req_write_o)
      ,.dram_req_ready_i (dram_req_ready_i)
      ,.accept_o         (accept)
      ,.accept_addr_o    (accept_addr)
      );

   dram_profiler #(.REGION_TOP(REGION_MSB)) profiler
     (.aclk           (aclk)
      ,.rst_n_i       (rst_n_i)
      ,.clear_i       (prof_clear)
      ,.accept_i      (accept)
      ,.accept_addr_i (accept_addr)
      ,.region_map_o  (region_map)
      ,.req_count_o   (req_count)
      );

endmodule
